// ==== src/exec_pkg.sv ====
package exec_pkg;

	// Operation codes presented by decode
	typedef enum logic [4:0] {
		OP_ADD    = 5'd0,
		OP_SUB    = 5'd1,
		OP_SLL    = 5'd2,
		OP_SLT    = 5'd3,
		OP_SLTU   = 5'd4,
		OP_XOR    = 5'd5,
		OP_SRL    = 5'd6,
		OP_SRA    = 5'd7,
		OP_OR     = 5'd8,
		OP_AND    = 5'd9,
		OP_SUBU   = 5'd10, // Compare mask, all ones when a < b unsigned
		OP_LUI    = 5'd11,
		OP_AUIPC  = 5'd12,

		// M extension
		OP_MUL    = 5'd13,
		OP_MULH   = 5'd14,
		OP_MULHSU = 5'd15,
		OP_MULHU  = 5'd16,
		OP_DIV    = 5'd17,
		OP_DIVU   = 5'd18,
		OP_REM    = 5'd19,
		OP_REMU   = 5'd20
	} alu_op_e;

	// Which datapath produces the result
	typedef enum logic [1:0] {
		CLASS_INT = 2'd0,
		CLASS_MUL = 2'd1,
		CLASS_DIV = 2'd2
	} op_class_e;

	// Final operands after second-operand selection
	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
	} operand_t;

	// Default pipeline depths of the multicycle units
	localparam int DEF_MUL_STAGES = 3;
	localparam int DEF_DIV_STAGES = 10;

endpackage

// ==== src/exec_control.sv ====
`timescale 1ns/1ps

module exec_control import exec_pkg::*; #(
	parameter int MUL_STAGES = DEF_MUL_STAGES,
	parameter int DIV_STAGES = DEF_DIV_STAGES
) (
	input  logic        clk,
	input  logic        reset,
	input  alu_op_e     alu_op,
	input  logic [31:0] int_result,
	input  logic [31:0] mul_result,
	input  logic [31:0] div_result,
	output logic        stall,
	output logic [31:0] result
);

	localparam int MAX_STAGES = (MUL_STAGES > DIV_STAGES) ? MUL_STAGES : DIV_STAGES;
	localparam int CNT_W = $clog2(MAX_STAGES + 1);

	op_class_e        op_class;
	logic [CNT_W-1:0] latency;
	logic [CNT_W-1:0] count;
	logic             busy;
	logic             done;      // Completion cycle, op is still on the inputs
	logic             new_multi;

	always_comb begin
		case (alu_op)
			OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: op_class = CLASS_MUL;
			OP_DIV, OP_DIVU, OP_REM, OP_REMU:     op_class = CLASS_DIV;
			default:                              op_class = CLASS_INT;
		endcase
	end

	always_comb begin
		case (op_class)
			CLASS_MUL: latency = CNT_W'(MUL_STAGES);
			CLASS_DIV: latency = CNT_W'(DIV_STAGES);
			default:   latency = '0;
		endcase
	end

	// A multicycle op seen while idle starts a new stall window
	assign new_multi = (op_class != CLASS_INT) && !busy && !done;
	assign stall = busy || new_multi;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			count <= '0;
		end else if (new_multi) begin
			count <= latency - 1'b1;
			busy  <= (latency > 1);
			done  <= (latency == 1);
		end else if (busy) begin
			count <= count - 1'b1;
			if (count == 1) begin // Last stall cycle
				busy <= 1'b0;
				done <= 1'b1;
			end
		end else begin
			done <= 1'b0; // Same op after this starts again
		end
	end

	always_comb begin
		case (op_class)
			CLASS_MUL: result = mul_result;
			CLASS_DIV: result = div_result;
			default:   result = int_result;
		endcase
	end

endmodule

// ==== src/int_alu.sv ====
`timescale 1ns/1ps

module int_alu import exec_pkg::*; (
	input  logic [31:0] rs1,
	input  logic [31:0] rs2,
	input  logic [31:0] itype_immed,
	input  logic        rs2_imm,
	input  logic [19:0] upper_immed,
	input  logic [31:0] pc,
	input  alu_op_e     alu_op,
	output operand_t    operands,
	output logic [31:0] int_result
);

	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] upper;
	logic [4:0]  shamt;

	assign a = rs1;
	assign b = rs2_imm ? itype_immed : rs2;

	assign operands.a = a;
	assign operands.b = b;

	assign upper = {upper_immed, 12'h000};
	assign shamt = b[4:0]; // Only the low five bits shift

	always_comb begin
		case (alu_op)
			OP_ADD: begin
				int_result = a + b;
			end
			OP_SUB: begin
				int_result = a - b;
			end
			OP_SLL: begin
				int_result = a << shamt;
			end
			OP_SLT: begin
				int_result = ($signed(a) < $signed(b)) ? 32'h1 : 32'h0;
			end
			OP_SLTU: begin
				int_result = (a < b) ? 32'h1 : 32'h0;
			end
			OP_XOR: begin
				int_result = a ^ b;
			end
			OP_SRL: begin
				int_result = a >> shamt;
			end
			OP_SRA: begin
				int_result = $unsigned($signed(a) >>> shamt);
			end
			OP_OR: begin
				int_result = a | b;
			end
			OP_AND: begin
				int_result = a & b;
			end
			OP_SUBU: begin
				int_result = (a >= b) ? 32'h0 : 32'hffff_ffff;
			end
			OP_LUI: begin
				int_result = upper;
			end
			OP_AUIPC: begin
				int_result = pc + upper; // Wraps, so negative offsets work
			end
			default: begin
				// Multiply and divide results come from their pipelines
				int_result = 32'h0;
			end
		endcase
	end

endmodule

// ==== src/mul_pipe.sv ====
`timescale 1ns/1ps

module mul_pipe import exec_pkg::*; #(
	parameter int MUL_STAGES = DEF_MUL_STAGES
) (
	input  logic        clk,
	input  logic        reset,
	input  alu_op_e     alu_op,
	input  operand_t    operands,
	output logic [31:0] mul_result
);

	// Product plus the word it will be read from
	typedef struct packed {
		logic        high;
		logic [63:0] prod;
	} mul_stage_t;

	logic [63:0] a_ext;
	logic [63:0] b_ext;
	mul_stage_t  in_stage;
	mul_stage_t  stage [MUL_STAGES];

	// MULHU: both unsigned, MULHSU: only b unsigned
	assign a_ext = (alu_op == OP_MULHU) ? {32'h0, operands.a} :
		{{32{operands.a[31]}}, operands.a};
	assign b_ext = (alu_op == OP_MULHU || alu_op == OP_MULHSU) ? {32'h0, operands.b} :
		{{32{operands.b[31]}}, operands.b};

	assign in_stage.prod = a_ext * b_ext;
	assign in_stage.high = (alu_op != OP_MUL);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < MUL_STAGES; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= in_stage;
			for (int i = 1; i < MUL_STAGES; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign mul_result = stage[MUL_STAGES-1].high ? stage[MUL_STAGES-1].prod[63:32] :
		stage[MUL_STAGES-1].prod[31:0];

endmodule

// ==== src/div_pipe.sv ====
`timescale 1ns/1ps

module div_pipe import exec_pkg::*; #(
	parameter int DIV_STAGES = DEF_DIV_STAGES
) (
	input  logic        clk,
	input  logic        reset,
	input  alu_op_e     alu_op,
	input  operand_t    operands,
	output logic [31:0] div_result
);

	logic        div_zero;
	logic        overflow;
	logic [31:0] divisor_u;
	logic [31:0] divisor_s;
	logic [31:0] quot_u;
	logic [31:0] rem_u;
	logic [31:0] quot_s;
	logic [31:0] rem_s;
	logic [31:0] sel_result;
	logic [31:0] stage [DIV_STAGES];

	assign div_zero = (operands.b == 32'h0);
	assign overflow = (operands.a == 32'h8000_0000) && (operands.b == 32'hffff_ffff);

	// Divide by one in the special cases, so overflow gives a and 0 for free
	assign divisor_u = div_zero ? 32'h1 : operands.b;
	assign divisor_s = (div_zero || overflow) ? 32'h1 : operands.b;

	assign quot_u = operands.a / divisor_u;
	assign rem_u  = operands.a % divisor_u;
	assign quot_s = $unsigned($signed(operands.a) / $signed(divisor_s));
	assign rem_s  = $unsigned($signed(operands.a) % $signed(divisor_s));

	always_comb begin
		case (alu_op)
			OP_DIV:  sel_result = div_zero ? 32'hffff_ffff : quot_s;
			OP_DIVU: sel_result = div_zero ? 32'hffff_ffff : quot_u;
			OP_REM:  sel_result = div_zero ? operands.a : rem_s;
			OP_REMU: sel_result = div_zero ? operands.a : rem_u;
			default: sel_result = 32'h0;
		endcase
	end

	// Fixed-latency delay to match the divider depth
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < DIV_STAGES; i++) begin
				stage[i] <= 32'h0;
			end
		end else begin
			stage[0] <= sel_result;
			for (int i = 1; i < DIV_STAGES; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign div_result = stage[DIV_STAGES-1];

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import exec_pkg::*; #(
	parameter int MUL_STAGES = DEF_MUL_STAGES,
	parameter int DIV_STAGES = DEF_DIV_STAGES
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] rs1,
	input  logic [31:0] rs2,
	input  logic        rs2_imm,
	input  logic [31:0] itype_immed,
	input  logic [19:0] upper_immed,
	input  logic [31:0] pc,
	input  alu_op_e     alu_op,
	output logic [31:0] result,
	output logic        stall
);

	operand_t    operands;
	logic [31:0] int_result;
	logic [31:0] mul_result;
	logic [31:0] div_result;

	int_alu u_int_alu (
		.rs1         (rs1),
		.rs2         (rs2),
		.itype_immed (itype_immed),
		.rs2_imm     (rs2_imm),
		.upper_immed (upper_immed),
		.pc          (pc),
		.alu_op      (alu_op),
		.operands    (operands),
		.int_result  (int_result)
	);

	mul_pipe #(.MUL_STAGES(MUL_STAGES)) u_mul (
		.clk        (clk),
		.reset      (reset),
		.alu_op     (alu_op),
		.operands   (operands),
		.mul_result (mul_result)
	);

	div_pipe #(.DIV_STAGES(DIV_STAGES)) u_div (
		.clk        (clk),
		.reset      (reset),
		.alu_op     (alu_op),
		.operands   (operands),
		.div_result (div_result)
	);

	exec_control #(
		.MUL_STAGES (MUL_STAGES),
		.DIV_STAGES (DIV_STAGES)
	) u_control (
		.clk        (clk),
		.reset      (reset),
		.alu_op     (alu_op),
		.int_result (int_result),
		.mul_result (mul_result),
		.div_result (div_result),
		.stall      (stall),
		.result     (result)
	);

endmodule

// ==== verification/exec_model.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Which datapath an operation belongs to
function automatic op_class_e model_class(input alu_op_e op);
	case (op)
		OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: return CLASS_MUL;
		OP_DIV, OP_DIVU, OP_REM, OP_REMU:     return CLASS_DIV;
		default:                              return CLASS_INT;
	endcase
endfunction

// Number of cycles with stall high before the answer appears
function automatic int model_latency(input alu_op_e op, input int mul_stages,
		input int div_stages);
	case (model_class(op))
		CLASS_MUL: return mul_stages;
		CLASS_DIV: return div_stages;
		default:   return 0;
	endcase
endfunction

// Expected result, b is the second operand after the immediate select
function automatic logic [31:0] model_result(input alu_op_e op, input logic [31:0] a,
		input logic [31:0] b, input logic [19:0] upper, input logic [31:0] pc_val);
	longint      sa;
	longint      sb;
	longint      ua;
	longint      ub;
	longint      prod;
	logic [31:0] imm20;
	int          sh;
	sa = $signed(a); // Sign extends to 64 bits
	sb = $signed(b);
	ua = {32'h0, a};
	ub = {32'h0, b};
	imm20 = 32'(upper) << 12;
	sh = b & 32'h1f;
	case (op)
		OP_ADD:   return a + b;
		OP_SUB:   return a - b;
		OP_SLL:   return a << sh;
		OP_SLT:   return (sa < sb) ? 32'h1 : 32'h0;
		OP_SLTU:  return (ua < ub) ? 32'h1 : 32'h0;
		OP_XOR:   return a ^ b;
		OP_SRL:   return a >> sh;
		OP_SRA:   return 32'(sa >>> sh);
		OP_OR:    return a | b;
		OP_AND:   return a & b;
		OP_SUBU:  return (ua < ub) ? 32'hffff_ffff : 32'h0;
		OP_LUI:   return imm20;
		OP_AUIPC: return pc_val + imm20;
		OP_MUL: begin
			prod = sa * sb;
			return prod[31:0];
		end
		OP_MULH: begin
			prod = sa * sb;
			return prod[63:32];
		end
		OP_MULHSU: begin
			prod = sa * ub;
			return prod[63:32];
		end
		OP_MULHU: begin
			prod = ua * ub; // Low 64 bits are the same signed or not
			return prod[63:32];
		end
		OP_DIV: begin
			if (b == 32'h0)
				return 32'hffff_ffff;
			if (a == 32'h8000_0000 && b == 32'hffff_ffff)
				return a;
			return 32'(sa / sb);
		end
		OP_DIVU:  return (b == 32'h0) ? 32'hffff_ffff : 32'(ua / ub);
		OP_REM: begin
			if (b == 32'h0)
				return a;
			return 32'(sa % sb); // Overflow case gives zero here
		end
		OP_REMU:  return (b == 32'h0) ? a : 32'(ua % ub);
		default:  return 32'h0;
	endcase
endfunction

`endif

// ==== verification/exec_unit_tb.sv ====
`timescale 1ns/1ps

module exec_unit_tb import exec_pkg::*; ();

	localparam int MUL_STAGES = DEF_MUL_STAGES;
	localparam int DIV_STAGES = DEF_DIV_STAGES;
	localparam int HALF_PERIOD = 20;
	localparam int SAMPLE_DELAY = HALF_PERIOD / 2; // Between falling and rising edge
	localparam int RESET_CYCLES = 16;
	localparam int RAND_LOOPS = 4;
	localparam int INT_EDGE_OPS = 12;
	localparam int N_EXTREME = 4;
	localparam int MAX_STALL = DIV_STAGES + 2;
	localparam int NUM_OPS = 1 + 13 * 2 * RAND_LOOPS + INT_EDGE_OPS
		+ 4 * (RAND_LOOPS + N_EXTREME * N_EXTREME) + 4 * RAND_LOOPS + 12 + 3;
	localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_OPS * (DIV_STAGES + 2) + 100)
		* 2 * HALF_PERIOD;

	logic        clk;
	logic        reset;
	logic [31:0] rs1;
	logic [31:0] rs2;
	logic        rs2_imm;
	logic [31:0] itype_immed;
	logic [19:0] upper_immed;
	logic [31:0] pc;
	alu_op_e     alu_op;
	logic [31:0] result;
	logic        stall;
	integer      seed = 32'he2b7;

	`include "exec_model.svh"

	exec_unit u_dut (
		.clk         (clk),
		.reset       (reset),
		.rs1         (rs1),
		.rs2         (rs2),
		.rs2_imm     (rs2_imm),
		.itype_immed (itype_immed),
		.upper_immed (upper_immed),
		.pc          (pc),
		.alu_op      (alu_op),
		.result      (result),
		.stall       (stall)
	);

	always #(HALF_PERIOD) clk = ~clk;

	task automatic fail_on_value(input string name, input logic [31:0] got,
			input logic [31:0] expected, input alu_op_e op);
		$display("Error: %s got 0x%h expected 0x%h (%s)", name, got, expected, op.name());
		$display("TEST FAILED");
		$fatal(1, "Stopping at the first mismatch");
	endtask

	task automatic fail_with_message(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Stopping after a failure");
	endtask

	// Drive one op, count stall cycles, then check the answer
	task automatic run_op(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
			input logic use_imm, input logic [31:0] imm, input logic [19:0] upper,
			input logic [31:0] pc_val);
		logic [31:0] exp_result;
		int          exp_stall;
		int          stall_cycles;
		exp_result = model_result(op, a, use_imm ? imm : b, upper, pc_val);
		exp_stall = model_latency(op, MUL_STAGES, DIV_STAGES);
		stall_cycles = 0;
		@(negedge clk);
		rs1 = a;
		rs2 = b;
		rs2_imm = use_imm;
		itype_immed = imm;
		upper_immed = upper;
		pc = pc_val;
		alu_op = op;
		#(SAMPLE_DELAY);
		while (stall && stall_cycles <= MAX_STALL) begin
			stall_cycles++;
			@(negedge clk);
			#(SAMPLE_DELAY);
		end
		assert (!stall) else
			fail_with_message($sformatf("Stall never fell on %s", op.name()));
		assert (stall_cycles == exp_stall) else
			fail_on_value("stall cycles", stall_cycles, exp_stall, op);
		assert (result === exp_result) else fail_on_value("result", result, exp_result, op);
	endtask

	task automatic test_reset_add();
		#(SAMPLE_DELAY);
		assert (stall === 1'b0) else fail_on_value("stall", 32'(stall), 32'h0, OP_ADD);
		run_op(OP_ADD, 32'h1234_5678, 32'h0fed_cba9, 1'b0, 32'h0, 20'h0, 32'h0);
	endtask

	task automatic test_int_ops();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] pc_val;
		logic [19:0] upper;
		for (int code = OP_ADD; code <= OP_AUIPC; code++) begin
			for (int src = 0; src < 2; src++) begin
				for (int n = 0; n < RAND_LOOPS; n++) begin
					a = $random(seed);
					b = $random(seed);
					imm = $random(seed);
					upper = 20'($random(seed));
					pc_val = $random(seed);
					run_op(alu_op_e'(code), a, b, src[0], imm, upper, pc_val);
				end
			end
		end
		// Shift amounts above 31
		run_op(OP_SLL, 32'h8000_0001, 32'h25, 1'b0, 32'h0, 20'h0, 32'h0);
		run_op(OP_SRL, 32'h8000_0f00, 32'h25, 1'b0, 32'h0, 20'h0, 32'h0);
		run_op(OP_SRA, 32'h8000_0f00, 32'h25, 1'b0, 32'h0, 20'h0, 32'h0);
		run_op(OP_SRA, 32'hf000_0000, 32'h0, 1'b1, 32'hffff_ffe3, 20'h0, 32'h0);
		run_op(OP_SLT, 32'h8000_0000, 32'h1, 1'b0, 32'h0, 20'h0, 32'h0);
		run_op(OP_SLTU, 32'h8000_0000, 32'h1, 1'b0, 32'h0, 20'h0, 32'h0);
		run_op(OP_SLT, 32'hffff_ffff, 32'h7fff_ffff, 1'b0, 32'h0, 20'h0, 32'h0);
		run_op(OP_SUBU, 32'h5, 32'h7, 1'b0, 32'h0, 20'h0, 32'h0);
		run_op(OP_SUBU, 32'h7, 32'h5, 1'b0, 32'h0, 20'h0, 32'h0);
		run_op(OP_SUBU, 32'h7, 32'h0, 1'b1, 32'h7, 20'h0, 32'h0);
		run_op(OP_LUI, 32'h0, 32'h0, 1'b0, 32'h0, 20'habcde, 32'h0);
		run_op(OP_AUIPC, 32'h0, 32'h0, 1'b0, 32'h0, 20'hfffff, 32'h0000_2000); // Minus 4096
	endtask

	task automatic test_mul_ops();
		logic [31:0] extremes [N_EXTREME] = '{32'h8000_0000, 32'hffff_ffff, 32'h0, 32'h7fff_ffff};
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		for (int code = OP_MUL; code <= OP_MULHU; code++) begin
			for (int i = 0; i < N_EXTREME; i++) begin
				for (int j = 0; j < N_EXTREME; j++) begin
					run_op(alu_op_e'(code), extremes[i], extremes[j], 1'b0, 32'h0, 20'h0, 32'h0);
				end
			end
			for (int n = 0; n < RAND_LOOPS; n++) begin
				a = $random(seed);
				b = $random(seed);
				imm = $random(seed);
				run_op(alu_op_e'(code), a, b, n[0], imm, 20'h0, 32'h0);
			end
		end
	endtask

	task automatic test_div_ops();
		logic [31:0] a;
		logic [31:0] b;
		for (int code = OP_DIV; code <= OP_REMU; code++) begin
			for (int n = 0; n < RAND_LOOPS; n++) begin
				a = $random(seed);
				b = $random(seed);
				if (n[0])
					b = $signed(b) >>> 20; // Small divisor, bigger quotient
				run_op(alu_op_e'(code), a, b, 1'b0, 32'h0, 20'h0, 32'h0);
			end
		end
	endtask

	task automatic test_div_special();
		for (int code = OP_DIV; code <= OP_REMU; code++) begin
			run_op(alu_op_e'(code), 32'h1234_5678, 32'h0, 1'b0, 32'h0, 20'h0, 32'h0);
			run_op(alu_op_e'(code), 32'h8000_0000, 32'h0, 1'b0, 32'h0, 20'h0, 32'h0);
			run_op(alu_op_e'(code), 32'h8000_0000, 32'hffff_ffff, 1'b0, 32'h0, 20'h0, 32'h0);
		end
	endtask

	task automatic test_back_to_back();
		logic [31:0] a;
		logic [31:0] b;
		a = $random(seed);
		b = $random(seed);
		run_op(OP_MULH, a, b, 1'b0, 32'h0, 20'h0, 32'h0);
		run_op(OP_DIV, b, a >> 8, 1'b0, 32'h0, 20'h0, 32'h0);
		run_op(OP_ADD, a, b, 1'b1, 32'hffff_fff0, 20'h0, 32'h0);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("TEST FAILED");
		$fatal(1, "Run stopped by the watchdog");
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		rs1 = 32'h0;
		rs2 = 32'h0;
		rs2_imm = 1'b0;
		itype_immed = 32'h0;
		upper_immed = 20'h0;
		pc = 32'h0;
		alu_op = OP_ADD;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset_add();
		test_int_ops();
		test_mul_ops();
		test_div_ops();
		test_div_special();
		test_back_to_back();
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== exec_unit.f ====
+incdir+verification
src/exec_pkg.sv
src/exec_control.sv
src/int_alu.sv
src/mul_pipe.sv
src/div_pipe.sv
src/exec_unit.sv
verification/exec_unit_tb.sv
